//--- src/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // ########################################################################
  // widths and constants
  // ########################################################################

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int csr_addr_w = 12;

  localparam logic [xlen-1:0] pc_invalid = '1;    // pc of an empty slot.
  localparam logic [xlen-1:0] pc_step    = 32'd4;

  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011,
    opc_load_fp  = 7'b0000111,
    opc_store_fp = 7'b0100111,
    opc_madd     = 7'b1000011,
    opc_op_fp    = 7'b1010011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_none
  } alu_op_e;

  typedef enum logic [2:0] {
    bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu, bcu_none
  } bcu_op_e;

  typedef enum logic [3:0] {
    lsu_lb, lsu_lh, lsu_lw, lsu_lbu, lsu_lhu, lsu_sb, lsu_sh, lsu_sw,
    lsu_flw, lsu_fsw, lsu_none
  } lsu_op_e;

  typedef enum logic [2:0] {
    csr_rw, csr_rs, csr_rc, csr_rwi, csr_rsi, csr_rci, csr_none
  } csr_op_e;

  typedef enum logic [2:0] {
    fpu_fadd, fpu_fsub, fpu_fmul, fpu_fdiv, fpu_fmadd, fpu_fmv_x_w, fpu_fmv_w_x, fpu_none
  } fpu_op_e;

  // ########################################################################
  // stage inputs
  // ########################################################################

  typedef struct packed {
    logic            ready;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } fetch_slot_t;

  typedef struct packed {
    fetch_slot_t slot0;
    fetch_slot_t slot1;
  } fetch_pair_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] taddr;
    logic [1:0]      tsat;
  } pred_t;

  typedef struct packed {
    pred_t pred0;
    pred_t pred1;
  } pred_pair_t;

  typedef struct packed {
    logic trap;
    logic mret;
    logic pred_miss;
    logic fence;
    logic wb_clear;
  } flush_t;

  // ########################################################################
  // decoder results
  // ########################################################################

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] imm;
    logic            wren, rden1, rden2, cwren, crden;
    logic            alunit, auipc, lui, jal, jalr, branch, load, store;
    logic            csreg, fence, ecall, ebreak, mret, wfi;
    alu_op_e         alu_op;
    bcu_op_e         bcu_op;
    lsu_op_e         lsu_op;
    csr_op_e         csr_op;
  } int_dec_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] imm;
    logic [1:0]      fmt;
    logic [2:0]      rm;
    logic            wren, rden1;
    logic            fwren, frden1, frden2, frden3, fload, fstore, fpunit;
    lsu_op_e         lsu_op;
    fpu_op_e         fpu_op;
  } fp_dec_t;

  typedef struct packed {
    logic valid, wren, rden1, rden2, cwren, crden;
    logic alunit, auipc, lui, jal, jalr, branch, load, store;
    logic csreg, fence, ecall, ebreak, mret, wfi;
    logic fwren, frden1, frden2, frden3, fload, fstore, fpunit;
    logic exception;
  } op_flags_t;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       npc;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] waddr;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [reg_addr_w-1:0] raddr3;
    logic [csr_addr_w-1:0] caddr;
    logic [1:0]            fmt;
    logic [2:0]            rm;
    op_flags_t             op;
    alu_op_e               alu_op;
    bcu_op_e               bcu_op;
    lsu_op_e               lsu_op;
    csr_op_e               csr_op;
    fpu_op_e               fpu_op;
    pred_t                 pred;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t instr0;
    decoded_instr_t instr1;
  } decode_out_t;

  localparam decoded_instr_t init_instruction = '{alu_op: alu_none, bcu_op: bcu_none,
      lsu_op: lsu_none, csr_op: csr_none, fpu_op: fpu_none, default: '0};

  localparam int_dec_t int_dec_none = '{alu_op: alu_none, bcu_op: bcu_none,
      lsu_op: lsu_none, csr_op: csr_none, default: '0};

  localparam fp_dec_t fp_dec_none = '{lsu_op: lsu_none, fpu_op: fpu_none, default: '0};

endpackage

`default_nettype wire

//--- src/int_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module int_decoder (
  input  logic [31:0]          instr,
  output decode_pkg::int_dec_t dec
);
  import decode_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = int_dec_none;
    case (opcode)
      opc_lui, opc_auipc: begin
        dec.valid = 1'b1;
        dec.wren  = 1'b1;
        dec.lui   = (opcode == opc_lui);
        dec.auipc = (opcode == opc_auipc);
        dec.imm   = imm_u;
      end
      opc_jal: begin
        dec.valid = 1'b1;
        dec.wren  = 1'b1;
        dec.jal   = 1'b1;
        dec.imm   = imm_j;
      end
      opc_jalr: begin
        dec.valid = (funct3 == 3'b000);
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.jalr  = 1'b1;
        dec.imm   = imm_i;
      end
      opc_branch: begin
        dec.rden1  = 1'b1;
        dec.rden2  = 1'b1;
        dec.branch = 1'b1;
        dec.imm    = imm_b;
        case (funct3)
          3'b000:  dec.bcu_op = bcu_beq;
          3'b001:  dec.bcu_op = bcu_bne;
          3'b100:  dec.bcu_op = bcu_blt;
          3'b101:  dec.bcu_op = bcu_bge;
          3'b110:  dec.bcu_op = bcu_bltu;
          3'b111:  dec.bcu_op = bcu_bgeu;
          default: dec.bcu_op = bcu_none;
        endcase
        dec.valid = (dec.bcu_op != bcu_none);
      end
      opc_load: begin
        dec.wren  = 1'b1;
        dec.rden1 = 1'b1;
        dec.load  = 1'b1;
        dec.imm   = imm_i;
        case (funct3)
          3'b000:  dec.lsu_op = lsu_lb;
          3'b001:  dec.lsu_op = lsu_lh;
          3'b010:  dec.lsu_op = lsu_lw;
          3'b100:  dec.lsu_op = lsu_lbu;
          3'b101:  dec.lsu_op = lsu_lhu;
          default: dec.lsu_op = lsu_none;
        endcase
        dec.valid = (dec.lsu_op != lsu_none);
      end
      opc_store: begin
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.store = 1'b1;
        dec.imm   = imm_s;
        case (funct3)
          3'b000:  dec.lsu_op = lsu_sb;
          3'b001:  dec.lsu_op = lsu_sh;
          3'b010:  dec.lsu_op = lsu_sw;
          default: dec.lsu_op = lsu_none;
        endcase
        dec.valid = (dec.lsu_op != lsu_none);
      end
      opc_op_imm: begin
        dec.wren   = 1'b1;
        dec.rden1  = 1'b1;
        dec.alunit = 1'b1;
        dec.imm    = imm_i;
        dec.alu_op = alu_func(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001) begin
          dec.valid = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          dec.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          dec.valid = 1'b1;
        end
      end
      opc_op: begin
        dec.wren   = 1'b1;
        dec.rden1  = 1'b1;
        dec.rden2  = 1'b1;
        dec.alunit = 1'b1;
        dec.alu_op = alu_func(funct3, funct7[5]);
        dec.valid  = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      opc_misc_mem: begin
        dec.fence = (funct3 == 3'b000);
        dec.valid = dec.fence;
      end
      opc_system: begin
        if (funct3 == 3'b000) begin
          dec.ecall  = (instr == 32'h00000073);
          dec.ebreak = (instr == 32'h00100073);
          dec.mret   = (instr == 32'h30200073);
          dec.wfi    = (instr == 32'h10500073);
          dec.valid  = dec.ecall | dec.ebreak | dec.mret | dec.wfi;
        end else begin
          dec.csreg = 1'b1;
          dec.wren  = 1'b1;
          dec.cwren = 1'b1;
          dec.crden = 1'b1;
          dec.rden1 = !funct3[2];               // immediate forms take rs1 as zimm.
          dec.imm   = {27'b0, instr[19:15]};
          case (funct3)
            3'b001:  dec.csr_op = csr_rw;
            3'b010:  dec.csr_op = csr_rs;
            3'b011:  dec.csr_op = csr_rc;
            3'b101:  dec.csr_op = csr_rwi;
            3'b110:  dec.csr_op = csr_rsi;
            3'b111:  dec.csr_op = csr_rci;
            default: dec.csr_op = csr_none;
          endcase
          dec.valid = (dec.csr_op != csr_none);
        end
      end
      default: ;
    endcase
    if (!dec.valid) begin
      dec = int_dec_none;                       // unknown words carry no flags.
    end
  end

  a_one_class: assert #0 (!dec.valid ||
      $onehot0({dec.load, dec.store, dec.branch, dec.jal, dec.jalr}))
    else $error("int_decoder: more than one control class for %h", instr);

endmodule

`default_nettype wire

//--- src/fp_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module fp_decoder (
  input  logic [31:0]         instr,
  output decode_pkg::fp_dec_t dec
);
  import decode_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [1:0] fmt;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct5 = instr[31:27];
  assign fmt    = instr[26:25];

  always_comb begin
    dec = fp_dec_none;
    case (opcode)
      opc_load_fp: begin
        dec.valid  = (funct3 == 3'b010);      // single precision only.
        dec.rden1  = 1'b1;
        dec.fwren  = 1'b1;
        dec.fload  = 1'b1;
        dec.lsu_op = lsu_flw;
        dec.imm    = {{20{instr[31]}}, instr[31:20]};
      end
      opc_store_fp: begin
        dec.valid  = (funct3 == 3'b010);
        dec.rden1  = 1'b1;
        dec.frden2 = 1'b1;
        dec.fstore = 1'b1;
        dec.lsu_op = lsu_fsw;
        dec.imm    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      opc_madd: begin
        dec.valid  = (fmt == 2'b00);
        dec.fmt    = fmt;
        dec.rm     = funct3;
        dec.fwren  = 1'b1;
        dec.frden1 = 1'b1;
        dec.frden2 = 1'b1;
        dec.frden3 = 1'b1;
        dec.fpunit = 1'b1;
        dec.fpu_op = fpu_fmadd;
      end
      opc_op_fp: begin
        dec.fmt    = fmt;
        dec.rm     = funct3;
        dec.fpunit = 1'b1;
        case (funct5)
          5'b00000, 5'b00001, 5'b00010, 5'b00011: begin
            dec.fwren  = 1'b1;
            dec.frden1 = 1'b1;
            dec.frden2 = 1'b1;
            dec.fpu_op = fpu_op_e'({1'b0, funct5[1:0]});   // fadd to fdiv in order.
          end
          5'b11100: begin
            dec.wren   = 1'b1;
            dec.frden1 = 1'b1;
            dec.fpu_op = (instr[24:20] == 5'b0 && funct3 == 3'b000) ? fpu_fmv_x_w : fpu_none;
          end
          5'b11110: begin
            dec.fwren  = 1'b1;
            dec.rden1  = 1'b1;
            dec.fpu_op = (instr[24:20] == 5'b0 && funct3 == 3'b000) ? fpu_fmv_w_x : fpu_none;
          end
          default: dec.fpu_op = fpu_none;
        endcase
        dec.valid = (fmt == 2'b00) && (dec.fpu_op != fpu_none);
      end
      default: ;
    endcase
    if (!dec.valid) begin
      dec = fp_dec_none;
    end
  end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  decode_pkg::fetch_pair_t fetch,
  input  decode_pkg::pred_pair_t  pred,
  input  decode_pkg::flush_t      flush,
  input  logic                    halt,
  input  decode_pkg::int_dec_t    int_dec0_in,
  input  decode_pkg::int_dec_t    int_dec1_in,
  input  decode_pkg::fp_dec_t     fp_dec0_in,
  input  decode_pkg::fp_dec_t     fp_dec1_in,
  output logic [31:0]             instr0_word,
  output logic [31:0]             instr1_word,
  output decode_pkg::decode_out_t q
);
  import decode_pkg::*;

  decode_out_t q_next;
  logic        squash;

  // the fp decoder result overrides the integer result on a hit.
  function automatic decoded_instr_t build_slot(
    input fetch_slot_t     f,
    input pred_t           p,
    input int_dec_t        id,
    input fp_dec_t         fd,
    input logic [xlen-1:0] word
  );
    decoded_instr_t s;
    s = init_instruction;
    s.pc     = f.ready ? f.pc : pc_invalid;
    s.npc    = s.pc + pc_step;
    s.instr  = word;
    s.waddr  = word[11:7];
    s.raddr1 = word[19:15];
    s.raddr2 = word[24:20];
    s.raddr3 = word[31:27];
    s.caddr  = word[31:20];
    s.pred   = p;
    s.imm       = id.imm;
    s.op.valid  = id.valid;
    s.op.wren   = id.wren;
    s.op.rden1  = id.rden1;
    s.op.rden2  = id.rden2;
    s.op.cwren  = id.cwren;
    s.op.crden  = id.crden;
    s.op.alunit = id.alunit;
    s.op.auipc  = id.auipc;
    s.op.lui    = id.lui;
    s.op.jal    = id.jal;
    s.op.jalr   = id.jalr;
    s.op.branch = id.branch;
    s.op.load   = id.load;
    s.op.store  = id.store;
    s.op.csreg  = id.csreg;
    s.op.fence  = id.fence;
    s.op.ecall  = id.ecall;
    s.op.ebreak = id.ebreak;
    s.op.mret   = id.mret;
    s.op.wfi    = id.wfi;
    s.alu_op    = id.alu_op;
    s.bcu_op    = id.bcu_op;
    s.lsu_op    = id.lsu_op;
    s.csr_op    = id.csr_op;
    if (fd.valid) begin
      s.imm       = fd.imm;
      s.fmt       = fd.fmt;
      s.rm        = fd.rm;
      s.op.valid  = fd.valid;
      s.op.wren   = fd.wren;
      s.op.rden1  = fd.rden1;
      s.op.fwren  = fd.fwren;
      s.op.frden1 = fd.frden1;
      s.op.frden2 = fd.frden2;
      s.op.frden3 = fd.frden3;
      s.op.fload  = fd.fload;
      s.op.fstore = fd.fstore;
      s.op.fpunit = fd.fpunit;
      s.lsu_op    = fd.lsu_op;
      s.fpu_op    = fd.fpu_op;
    end
    if (f.ready && !s.op.valid) begin
      s.op.valid     = 1'b1;                    // illegal instruction.
      s.op.exception = 1'b1;
    end
    return s;
  endfunction

  assign instr0_word = fetch.slot0.ready ? fetch.slot0.instr : '0;
  assign instr1_word = fetch.slot1.ready ? fetch.slot1.instr : '0;
  assign squash      = halt | (|flush);

  always_comb begin
    q_next.instr0 = build_slot(fetch.slot0, pred.pred0, int_dec0_in, fp_dec0_in, instr0_word);
    q_next.instr1 = build_slot(fetch.slot1, pred.pred1, int_dec1_in, fp_dec1_in, instr1_word);
    if (squash) begin
      q_next.instr0 = init_instruction;
      q_next.instr1 = init_instruction;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      q.instr0 <= init_instruction;
      q.instr1 <= init_instruction;
    end else begin
      q <= q_next;
    end
  end

  a_squash: assert property (@(posedge clock) disable iff (!reset)
      (halt || (|flush)) |=> (!q.instr0.op.valid && !q.instr1.op.valid))
    else $error("decode_stage: slot valid after flush or halt");

  a_exc_valid: assert property (@(posedge clock) disable iff (!reset)
      (!q.instr0.op.exception || q.instr0.op.valid) &&
      (!q.instr1.op.exception || q.instr1.op.valid))
    else $error("decode_stage: exception without valid");

endmodule

`default_nettype wire

//--- src/decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_top (
  input  logic                    clock,
  input  logic                    reset,
  input  decode_pkg::fetch_pair_t fetch,
  input  decode_pkg::pred_pair_t  pred,
  input  decode_pkg::flush_t      flush,
  input  logic                    halt,
  output decode_pkg::decode_out_t q
);
  import decode_pkg::*;

  logic [31:0] instr0_word, instr1_word;
  int_dec_t    int_dec0, int_dec1;
  fp_dec_t     fp_dec0, fp_dec1;

  // ########################################################################
  // per-slot decoders
  // ########################################################################

  int_decoder u_int_dec0 (.instr(instr0_word), .dec(int_dec0));
  int_decoder u_int_dec1 (.instr(instr1_word), .dec(int_dec1));
  fp_decoder  u_fp_dec0  (.instr(instr0_word), .dec(fp_dec0));
  fp_decoder  u_fp_dec1  (.instr(instr1_word), .dec(fp_dec1));

  decode_stage u_stage (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .pred        (pred),
    .flush       (flush),
    .halt        (halt),
    .int_dec0_in (int_dec0),
    .int_dec1_in (int_dec1),
    .fp_dec0_in  (fp_dec0),
    .fp_dec1_in  (fp_dec1),
    .instr0_word (instr0_word),
    .instr1_word (instr1_word),
    .q           (q)
  );

endmodule

`default_nettype wire

//--- tb/decode_tests.svh
  // ########################################################################
  // directed tests
  // ########################################################################

  // one random pair through the stage, squashed when halt or a flush bit is set.
  task automatic decode_pair(input kind_e k0, input kind_e k1, input logic r0, input logic r1,
                             input flush_t fl, input logic h);
    operands_t      o0, o1;
    fetch_pair_t    f;
    pred_pair_t     p;
    decoded_instr_t e0, e1;
    o0       = random_operands();
    o1       = random_operands();
    f.slot0  = make_slot(k0, o0, r0);
    f.slot1  = make_slot(k1, o1, r1);
    p.pred0  = random_pred();
    p.pred1  = random_pred();
    e0       = expect_slot(k0, f.slot0, p.pred0, o0);
    e1       = expect_slot(k1, f.slot1, p.pred1, o1);
    if (h || (|fl)) begin
      e0 = init_instruction;
      e1 = init_instruction;
    end
    run_pair(f, p, fl, h, e0, e1);
  endtask

  task automatic check_after_reset();
    compare_slot("q.instr0", init_instruction, q.instr0);
    compare_slot("q.instr1", init_instruction, q.instr1);
  endtask

  task automatic integer_decode();
    kind_e kinds [8];
    kinds = '{k_add, k_addi, k_lw, k_sw, k_beq, k_jal, k_lui, k_csrrw};
    for (int i = 0; i < 16; i++) begin
      decode_pair(kinds[i % 8], kinds[(i + 3) % 8], 1'b1, 1'b1, '0, 1'b0);
    end
  endtask

  task automatic float_override();
    kind_e kinds [5];
    kinds = '{k_flw, k_fsw, k_fadd, k_fmadd, k_fmv_x_w};
    for (int i = 0; i < 10; i++) begin
      decode_pair(kinds[i % 5], kinds[(i + 2) % 5], 1'b1, 1'b1, '0, 1'b0);
    end
    decode_pair(k_fmadd, k_add, 1'b1, 1'b1, '0, 1'b0);     // mixed pair.
    decode_pair(k_lw, k_fmv_x_w, 1'b1, 1'b1, '0, 1'b0);
  endtask

  task automatic empty_and_illegal();
    decode_pair(k_add, k_lw, 1'b0, 1'b1, '0, 1'b0);        // slot0 not ready.
    decode_pair(k_fadd, k_sw, 1'b1, 1'b0, '0, 1'b0);
    decode_pair(k_illegal, k_beq, 1'b1, 1'b1, '0, 1'b0);
    decode_pair(k_jal, k_illegal, 1'b1, 1'b1, '0, 1'b0);
    decode_pair(k_illegal, k_illegal, 1'b1, 1'b0, '0, 1'b0);
  endtask

  // each flush source in turn, then halt, each followed by a normal pair.
  task automatic squash_and_resume();
    for (int i = 0; i < 5; i++) begin
      decode_pair(k_add, k_flw, 1'b1, 1'b1, flush_t'(5'b00001 << i), 1'b0);
      decode_pair(k_sw, k_jal, 1'b1, 1'b1, '0, 1'b0);
    end
    decode_pair(k_fadd, k_beq, 1'b1, 1'b1, '0, 1'b1);
    decode_pair(k_lui, k_csrrw, 1'b1, 1'b1, '0, 1'b0);
  endtask

  task automatic prediction_passthrough();
    for (int i = 0; i < 6; i++) begin
      decode_pair(k_beq, k_jal, 1'b1, i[0], '0, 1'b0);
    end
  endtask

//--- tb/decode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_tb;
  import decode_pkg::*;

  typedef enum logic [3:0] {
    k_add, k_addi, k_lw, k_sw, k_beq, k_jal, k_lui, k_csrrw,
    k_flw, k_fsw, k_fadd, k_fmadd, k_fmv_x_w, k_illegal
  } kind_e;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rs3;
    logic [2:0]  rm;
    logic [19:0] raw;    // immediate bits placed per format.
  } operands_t;

  logic        clock;
  logic        reset;
  fetch_pair_t fetch;
  pred_pair_t  pred;
  flush_t      flush;
  logic        halt;
  decode_out_t q;

  integer seed;
  int     errors;
  int     checks;
  int     edges = 0;

  decoded_instr_t last0;    // what q holds until the next edge.
  decoded_instr_t last1;

  decode_top u_dut (
    .clock (clock),
    .reset (reset),
    .fetch (fetch),
    .pred  (pred),
    .flush (flush),
    .halt  (halt),
    .q     (q)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) edges <= edges + 1;

  // ########################################################################
  // timing and checks
  // ########################################################################

  task automatic wait_cycles(input int n);
    int target;
    int polls;
    target = edges + n;
    polls  = 0;
    while (edges < target && polls < 10 * n) begin
      #10;                                      // polls land between the edges.
      polls++;
    end
    if (edges < target) begin
      $display("timeout: clock stopped, no rising edge after %0d polls", polls);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] e, input logic [63:0] a);
    checks++;
    assert (a === e) else begin
      errors++;
      $display("MISMATCH at %0d ns: %s expected %h, actual %h", $time, name, e, a);
    end
  endtask

  task automatic compare_slot(input string which, input decoded_instr_t e,
                              input decoded_instr_t a);
    check_field({which, ".pc"}, e.pc, a.pc);
    check_field({which, ".npc"}, e.npc, a.npc);
    check_field({which, ".instr"}, e.instr, a.instr);
    check_field({which, ".imm"}, e.imm, a.imm);
    check_field({which, ".waddr"}, e.waddr, a.waddr);
    check_field({which, ".raddr1"}, e.raddr1, a.raddr1);
    check_field({which, ".raddr2"}, e.raddr2, a.raddr2);
    check_field({which, ".raddr3"}, e.raddr3, a.raddr3);
    check_field({which, ".caddr"}, e.caddr, a.caddr);
    check_field({which, ".fmt"}, e.fmt, a.fmt);
    check_field({which, ".rm"}, e.rm, a.rm);
    check_field({which, ".op"}, e.op, a.op);
    check_field({which, ".alu_op"}, e.alu_op, a.alu_op);
    check_field({which, ".bcu_op"}, e.bcu_op, a.bcu_op);
    check_field({which, ".lsu_op"}, e.lsu_op, a.lsu_op);
    check_field({which, ".csr_op"}, e.csr_op, a.csr_op);
    check_field({which, ".fpu_op"}, e.fpu_op, a.fpu_op);
    check_field({which, ".pred"}, e.pred, a.pred);
  endtask

  // ########################################################################
  // stimulus and reference model
  // ########################################################################

  function automatic operands_t random_operands();
    operands_t o;
    o.rd  = $random(seed);
    o.rs1 = $random(seed);
    o.rs2 = $random(seed);
    o.rs3 = $random(seed);
    o.rm  = $random(seed);
    o.raw = $random(seed);
    return o;
  endfunction

  function automatic pred_t random_pred();
    pred_t p;
    p.taken = $random(seed);
    p.taddr = $random(seed);
    p.tsat  = $random(seed);
    return p;
  endfunction

  function automatic logic [31:0] encode_word(input kind_e k, input operands_t o);
    case (k)
      k_add:     return {7'b0000000, o.rs2, o.rs1, 3'b000, o.rd, 7'b0110011};
      k_addi:    return {o.raw[11:0], o.rs1, 3'b000, o.rd, 7'b0010011};
      k_lw:      return {o.raw[11:0], o.rs1, 3'b010, o.rd, 7'b0000011};
      k_sw:      return {o.raw[11:5], o.rs2, o.rs1, 3'b010, o.raw[4:0], 7'b0100011};
      k_beq:     return {o.raw[11], o.raw[9:4], o.rs2, o.rs1, 3'b000, o.raw[3:0], o.raw[10],
                         7'b1100011};
      k_jal:     return {o.raw[19], o.raw[9:0], o.raw[10], o.raw[18:11], o.rd, 7'b1101111};
      k_lui:     return {o.raw, o.rd, 7'b0110111};
      k_csrrw:   return {o.raw[11:0], o.rs1, 3'b001, o.rd, 7'b1110011};
      k_flw:     return {o.raw[11:0], o.rs1, 3'b010, o.rd, 7'b0000111};
      k_fsw:     return {o.raw[11:5], o.rs2, o.rs1, 3'b010, o.raw[4:0], 7'b0100111};
      k_fadd:    return {7'b0000000, o.rs2, o.rs1, o.rm, o.rd, 7'b1010011};
      k_fmadd:   return {o.rs3, 2'b00, o.rs2, o.rs1, o.rm, o.rd, 7'b1000011};
      k_fmv_x_w: return {7'b1110000, 5'b00000, o.rs1, 3'b000, o.rd, 7'b1010011};
      default:   return 32'hffff_ffff;          // no opcode of the subset.
    endcase
  endfunction

  function automatic logic [31:0] imm_value(input kind_e k, input operands_t o);
    case (k)
      k_addi, k_lw, k_sw, k_flw, k_fsw: return {{20{o.raw[11]}}, o.raw[11:0]};
      k_beq:   return {{19{o.raw[11]}}, o.raw[11:0], 1'b0};
      k_jal:   return {{11{o.raw[19]}}, o.raw[19:0], 1'b0};
      k_lui:   return {o.raw, 12'b0};
      k_csrrw: return {27'b0, o.rs1};
      default: return 32'b0;
    endcase
  endfunction

  function automatic fetch_slot_t make_slot(input kind_e k, input operands_t o, input logic ready);
    fetch_slot_t f;
    f.ready = ready;
    f.pc    = {$random(seed)} & 32'hffff_fffc;
    f.instr = encode_word(k, o);
    return f;
  endfunction

  // pc, npc, word, address fields and prediction of a slot.
  function automatic decoded_instr_t frame_slot(input fetch_slot_t f, input pred_t p);
    decoded_instr_t s;
    logic [31:0]    word;
    word     = f.ready ? f.instr : 32'b0;
    s        = init_instruction;
    s.pc     = f.ready ? f.pc : pc_invalid;
    s.npc    = s.pc + pc_step;
    s.instr  = word;
    s.waddr  = word[11:7];
    s.raddr1 = word[19:15];
    s.raddr2 = word[24:20];
    s.raddr3 = word[31:27];
    s.caddr  = word[31:20];
    s.pred   = p;
    return s;
  endfunction

  function automatic decoded_instr_t expect_slot(input kind_e k, input fetch_slot_t f,
                                                 input pred_t p, input operands_t o);
    decoded_instr_t s;
    s = frame_slot(f, p);
    if (!f.ready) begin
      return s;
    end
    s.imm = imm_value(k, o);
    case (k)
      k_add: begin
        s.op     = '{valid: 1'b1, wren: 1'b1, rden1: 1'b1, rden2: 1'b1, alunit: 1'b1,
                     default: 1'b0};
        s.alu_op = alu_add;
      end
      k_addi: begin
        s.op     = '{valid: 1'b1, wren: 1'b1, rden1: 1'b1, alunit: 1'b1, default: 1'b0};
        s.alu_op = alu_add;
      end
      k_lw: begin
        s.op     = '{valid: 1'b1, wren: 1'b1, rden1: 1'b1, load: 1'b1, default: 1'b0};
        s.lsu_op = lsu_lw;
      end
      k_sw: begin
        s.op     = '{valid: 1'b1, rden1: 1'b1, rden2: 1'b1, store: 1'b1, default: 1'b0};
        s.lsu_op = lsu_sw;
      end
      k_beq: begin
        s.op     = '{valid: 1'b1, rden1: 1'b1, rden2: 1'b1, branch: 1'b1, default: 1'b0};
        s.bcu_op = bcu_beq;
      end
      k_jal: s.op = '{valid: 1'b1, wren: 1'b1, jal: 1'b1, default: 1'b0};
      k_lui: s.op = '{valid: 1'b1, wren: 1'b1, lui: 1'b1, default: 1'b0};
      k_csrrw: begin
        s.op     = '{valid: 1'b1, wren: 1'b1, rden1: 1'b1, cwren: 1'b1, crden: 1'b1,
                     csreg: 1'b1, default: 1'b0};
        s.csr_op = csr_rw;
      end
      k_flw: begin
        s.op     = '{valid: 1'b1, rden1: 1'b1, fwren: 1'b1, fload: 1'b1, default: 1'b0};
        s.lsu_op = lsu_flw;
      end
      k_fsw: begin
        s.op     = '{valid: 1'b1, rden1: 1'b1, frden2: 1'b1, fstore: 1'b1, default: 1'b0};
        s.lsu_op = lsu_fsw;
      end
      k_fadd: begin
        s.op     = '{valid: 1'b1, fwren: 1'b1, frden1: 1'b1, frden2: 1'b1, fpunit: 1'b1,
                     default: 1'b0};
        s.fpu_op = fpu_fadd;
        s.rm     = o.rm;
      end
      k_fmadd: begin
        s.op     = '{valid: 1'b1, fwren: 1'b1, frden1: 1'b1, frden2: 1'b1, frden3: 1'b1,
                     fpunit: 1'b1, default: 1'b0};
        s.fpu_op = fpu_fmadd;
        s.rm     = o.rm;
      end
      k_fmv_x_w: begin
        s.op     = '{valid: 1'b1, wren: 1'b1, frden1: 1'b1, fpunit: 1'b1, default: 1'b0};
        s.fpu_op = fpu_fmv_x_w;
      end
      default: s.op = '{valid: 1'b1, exception: 1'b1, default: 1'b0};
    endcase
    return s;
  endfunction

  task automatic run_pair(input fetch_pair_t f, input pred_pair_t p, input flush_t fl,
                          input logic h, input decoded_instr_t e0, input decoded_instr_t e1);
    fetch = f;
    pred  = p;
    flush = fl;
    halt  = h;
    #10;                                        // q holds the previous pair until the edge.
    compare_slot("q.instr0", last0, q.instr0);
    compare_slot("q.instr1", last1, q.instr1);
    wait_cycles(1);                             // fixed one-cycle latency.
    compare_slot("q.instr0", e0, q.instr0);
    compare_slot("q.instr1", e1, q.instr1);
    last0 = e0;
    last1 = e1;
  endtask

  `include "decode_tests.svh"

  initial begin
    seed   = 32'h5a36;
    errors = 0;
    checks = 0;
    last0  = init_instruction;
    last1  = init_instruction;
    reset  = 1'b0;
    fetch  = '0;
    pred   = '0;
    flush  = '0;
    halt   = 1'b0;
    #2;
    wait_cycles(2);
    reset = 1'b1;
    check_after_reset();
    integer_decode();
    float_override();
    empty_and_illegal();
    squash_and_resume();
    prediction_passthrough();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tb
src/decode_pkg.sv
src/int_decoder.sv
src/fp_decoder.sv
src/decode_stage.sv
src/decode_top.sv
tb/decode_tb.sv
